//--- hw/cache_ctrl.sv
// request FSM for lookup, hit handling and miss sequencing through dma commands
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
  #(parameter int sets_p = 16,
    parameter int ways_p = 2,
    parameter int block_size_in_words_p = 4,
    localparam int lg_sets_lp = $clog2(sets_p),
    localparam int lg_ways_lp = $clog2(ways_p),
    localparam int lg_block_lp = $clog2(block_size_in_words_p),
    localparam int block_offset_lp = lg_block_lp + 2,
    localparam int tag_width_lp = addr_width_c - lg_sets_lp - block_offset_lp
  ) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  cache_req_s                          req_i,
    input  logic                                req_v_i,
    output logic                                req_yumi_o,
    output cache_resp_s                         resp_o,
    output logic                                resp_v_o,
    input  logic                                resp_yumi_i,
    output logic                                tag_v_o,
    output logic [lg_sets_lp-1:0]               tag_index_o,
    output logic [tag_width_lp-1:0]             tag_o,
    output logic                                tag_w_o,
    output logic [lg_ways_lp-1:0]               tag_w_way_o,
    output logic                                tag_set_dirty_o,
    input  logic                                tag_hit_i,
    input  logic [lg_ways_lp-1:0]               tag_hit_way_i,
    input  logic [lg_ways_lp-1:0]               victim_way_i,
    input  logic [tag_width_lp-1:0]             victim_tag_i,
    input  logic                                victim_dirty_i,
    output logic                                data_mem_v_o,
    output logic                                data_mem_w_o,
    output logic [lg_sets_lp+lg_block_lp-1:0]   data_mem_addr_o,
    output logic [ways_p-1:0]                   data_mem_w_mask_o,
    output logic [data_width_c-1:0]             data_mem_data_o,
    input  logic [ways_p-1:0][data_width_c-1:0] data_mem_data_i,
    output logic                                dma_active_o,
    output dma_cmd_e                            dma_cmd_o,
    output logic [lg_ways_lp-1:0]               dma_way_o,
    output logic [addr_width_c-1:0]             dma_addr_o,
    input  logic                                dma_done_i,
    input  logic [data_width_c-1:0]             snoop_word_i
  );

  typedef enum logic [2:0] {
    e_idle,
    e_lookup,
    e_evict_addr,
    e_evict_data,
    e_fill_addr,
    e_fill_data,
    e_finish,
    e_respond
  } ctrl_state_e;

  ctrl_state_e state_r, state_n;
  cache_req_s  req_r;
  cache_resp_s resp_r;
  logic [lg_ways_lp-1:0]   miss_way_r;
  logic [addr_width_c-1:0] cur_addr;
  logic is_store, store_write, evicting;

  // the incoming request is decoded directly in the accept cycle
  assign cur_addr = (state_r == e_idle) ? req_i.addr : req_r.addr;
  assign is_store = (req_r.op == e_op_store);
  assign store_write = is_store && (((state_r == e_lookup) && tag_hit_i) || (state_r == e_finish));
  assign evicting = (state_r == e_evict_addr) || (state_r == e_evict_data);

  assign req_yumi_o = (state_r == e_idle) & req_v_i;
  assign resp_v_o = (state_r == e_respond);
  assign resp_o = resp_r;

  assign tag_v_o = req_yumi_o;
  assign tag_index_o = cur_addr[block_offset_lp +: lg_sets_lp];
  assign tag_o = req_r.addr[addr_width_c-1 -: tag_width_lp];
  assign tag_w_o = (state_r == e_fill_data) & dma_done_i;
  assign tag_w_way_o = (state_r == e_lookup) ? tag_hit_way_i : miss_way_r;
  assign tag_set_dirty_o = store_write;

  assign data_mem_v_o = req_yumi_o | store_write;
  assign data_mem_w_o = store_write;
  assign data_mem_addr_o = cur_addr[2 +: lg_sets_lp + lg_block_lp];
  assign data_mem_w_mask_o = ways_p'(1) << tag_w_way_o;
  assign data_mem_data_o = req_r.data;

  assign dma_active_o = evicting || (state_r == e_fill_addr) || (state_r == e_fill_data);
  assign dma_way_o = miss_way_r;
  // victim block address is rebuilt from its stored tag
  assign dma_addr_o = evicting
    ? {victim_tag_i, req_r.addr[block_offset_lp +: lg_sets_lp], {block_offset_lp{1'b0}}}
    : req_r.addr;

  always_comb begin
    case (state_r)
      e_evict_addr: dma_cmd_o = e_dma_send_evict_addr;
      e_evict_data: dma_cmd_o = e_dma_send_evict_data;
      e_fill_addr:  dma_cmd_o = e_dma_send_fill_addr;
      e_fill_data:  dma_cmd_o = e_dma_get_fill_data;
      default:      dma_cmd_o = e_dma_nop;
    endcase
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle:       if (req_v_i) state_n = e_lookup;
      e_lookup: begin
        if (tag_hit_i) begin
          state_n = e_respond;
        end else if (victim_dirty_i) begin
          state_n = e_evict_addr;
        end else begin
          state_n = e_fill_addr;
        end
      end
      e_evict_addr: if (dma_done_i) state_n = e_evict_data;
      e_evict_data: if (dma_done_i) state_n = e_fill_addr;
      e_fill_addr:  if (dma_done_i) state_n = e_fill_data;
      e_fill_data:  if (dma_done_i) state_n = e_finish;
      e_finish:     state_n = e_respond;
      e_respond:    if (resp_yumi_i) state_n = e_idle;
      default:      state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      req_r <= req_i;
    end
    if (state_r == e_lookup) begin
      miss_way_r <= victim_way_i;
    end
    // hit data comes from the array and miss data from the fill snoop
    if ((state_r == e_lookup || state_r == e_finish) && state_n == e_respond) begin
      resp_r.op <= req_r.op;
      if (is_store) begin
        resp_r.data <= '0;
      end else if (state_r == e_lookup) begin
        resp_r.data <= data_mem_data_i[tag_hit_way_i];
      end else begin
        resp_r.data <= snoop_word_i;
      end
    end
  end

  // the dma engine only reports done for a command in flight
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_done_i |-> (dma_cmd_o != e_dma_nop));

endmodule

//--- hw/cache_data_mem.sv
// one-port synchronous word array holding every way, with per-way write masks
`timescale 1ns/1ps

module cache_data_mem
  import cache_pkg::*;
  #(parameter int sets_p = 16,
    parameter int ways_p = 2,
    parameter int block_size_in_words_p = 4,
    localparam int addr_width_lp = $clog2(sets_p) + $clog2(block_size_in_words_p),
    localparam int depth_lp = sets_p * block_size_in_words_p
  ) (
    input  logic                                 clk_i,
    input  logic                                 v_i,
    input  logic                                 w_i,
    input  logic [addr_width_lp-1:0]             addr_i,
    input  logic [ways_p-1:0]                    w_mask_i,
    input  logic [data_width_c-1:0]              data_i,
    output logic [ways_p-1:0][data_width_c-1:0]  data_o
  );

  logic [ways_p-1:0][data_width_c-1:0] mem_r [depth_lp];

  // data_o keeps the last read until the next read
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        for (int w = 0; w < ways_p; w++) begin
          if (w_mask_i[w]) begin
            mem_r[addr_i][w] <= data_i;
          end
        end
      end else begin
        data_o <= mem_r[addr_i];
      end
    end
  end

endmodule

//--- hw/cache_dma.sv
// block transfer engine with fill and evict fifos, word counter and snoop capture
`timescale 1ns/1ps

module cache_dma
  import cache_pkg::*;
  #(parameter int sets_p = 16,
    parameter int ways_p = 2,
    parameter int block_size_in_words_p = 4,
    localparam int lg_sets_lp = $clog2(sets_p),
    localparam int lg_ways_lp = $clog2(ways_p),
    localparam int lg_block_lp = $clog2(block_size_in_words_p),
    localparam int block_offset_lp = lg_block_lp + 2,
    localparam int cnt_width_lp = $clog2(block_size_in_words_p + 1)
  ) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  dma_cmd_e                            dma_cmd_i,
    input  logic [lg_ways_lp-1:0]               dma_way_i,
    input  logic [addr_width_c-1:0]             dma_addr_i,
    output logic                                done_o,
    output logic [data_width_c-1:0]             snoop_word_o,
    output dma_pkt_s                            dma_pkt_o,
    output logic                                dma_pkt_v_o,
    input  logic                                dma_pkt_yumi_i,
    input  logic [data_width_c-1:0]             dma_data_i,
    input  logic                                dma_data_v_i,
    output logic                                dma_data_ready_o,
    output logic [data_width_c-1:0]             dma_data_o,
    output logic                                dma_data_v_o,
    input  logic                                dma_data_yumi_i,
    output logic                                data_mem_v_o,
    output logic                                data_mem_w_o,
    output logic [lg_sets_lp+lg_block_lp-1:0]   data_mem_addr_o,
    output logic [ways_p-1:0]                   data_mem_w_mask_o,
    output logic [data_width_c-1:0]             data_mem_data_o,
    input  logic [ways_p-1:0][data_width_c-1:0] data_mem_data_i
  );

  typedef enum logic [1:0] {
    e_idle,
    e_get_fill_data,
    e_send_evict_data
  } dma_state_e;

  dma_state_e state_r, state_n;
  logic [cnt_width_lp-1:0] cnt_r;
  logic cnt_up, cnt_clear;
  logic fill_last, evict_last;
  logic snoop_we;

  logic [data_width_c-1:0] in_mem_r [block_size_in_words_p];
  logic [lg_block_lp-1:0]  in_wptr_r, in_rptr_r;
  logic [cnt_width_lp-1:0] in_count_r;
  logic in_v, in_enq, in_yumi;

  logic [data_width_c-1:0] out_mem_r [2];
  logic       out_wptr_r, out_rptr_r;
  logic [1:0] out_count_r;
  logic out_v, out_ready, out_enq;

  // in fifo, one block deep
  assign dma_data_ready_o = (in_count_r != cnt_width_lp'(block_size_in_words_p));
  assign in_enq = dma_data_v_i & dma_data_ready_o;
  assign in_v = (in_count_r != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_wptr_r <= '0;
      in_rptr_r <= '0;
      in_count_r <= '0;
    end else begin
      in_wptr_r <= in_wptr_r + lg_block_lp'(in_enq);
      in_rptr_r <= in_rptr_r + lg_block_lp'(in_yumi);
      in_count_r <= in_count_r + cnt_width_lp'(in_enq) - cnt_width_lp'(in_yumi);
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_enq) begin
      in_mem_r[in_wptr_r] <= dma_data_i;
    end
  end

  // two-entry out fifo toward memory
  assign out_ready = (out_count_r != 2'd2);
  assign out_enq = out_v & out_ready;
  assign dma_data_v_o = (out_count_r != 2'd0);
  assign dma_data_o = out_mem_r[out_rptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_wptr_r <= 1'b0;
      out_rptr_r <= 1'b0;
      out_count_r <= 2'd0;
    end else begin
      out_wptr_r <= out_wptr_r ^ out_enq;
      out_rptr_r <= out_rptr_r ^ dma_data_yumi_i;
      out_count_r <= out_count_r + 2'(out_enq) - 2'(dma_data_yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_enq) begin
      out_mem_r[out_wptr_r] <= data_mem_data_i[dma_way_i];
    end
  end

  // word counter, back at zero whenever the engine is idle
  assign fill_last = (cnt_r == cnt_width_lp'(block_size_in_words_p - 1));
  assign evict_last = (cnt_r == cnt_width_lp'(block_size_in_words_p));

  always_ff @(posedge clk_i) begin
    if (reset_i || cnt_clear) begin
      cnt_r <= '0;
    end else if (cnt_up) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  assign dma_pkt_o.write_not_read = (dma_cmd_i == e_dma_send_evict_addr);
  assign dma_pkt_o.addr = {dma_addr_i[addr_width_c-1:block_offset_lp], {block_offset_lp{1'b0}}};

  assign data_mem_addr_o = {dma_addr_i[block_offset_lp +: lg_sets_lp], cnt_r[lg_block_lp-1:0]};
  assign data_mem_w_mask_o = ways_p'(1) << dma_way_i;
  assign data_mem_data_o = in_mem_r[in_rptr_r];

  always_comb begin
    state_n = state_r;
    done_o = 1'b0;
    dma_pkt_v_o = 1'b0;
    data_mem_v_o = 1'b0;
    data_mem_w_o = 1'b0;
    in_yumi = 1'b0;
    out_v = 1'b0;
    cnt_up = 1'b0;
    cnt_clear = 1'b0;
    case (state_r)
      e_idle: begin
        case (dma_cmd_i)
          e_dma_send_fill_addr, e_dma_send_evict_addr: begin
            dma_pkt_v_o = 1'b1;
            done_o = dma_pkt_yumi_i;
          end
          e_dma_get_fill_data: begin
            state_n = e_get_fill_data;
          end
          // word 0 is read on the way out of idle
          e_dma_send_evict_data: begin
            data_mem_v_o = 1'b1;
            cnt_up = 1'b1;
            state_n = e_send_evict_data;
          end
          default: begin
          end
        endcase
      end
      e_get_fill_data: begin
        data_mem_v_o = in_v;
        data_mem_w_o = in_v;
        in_yumi = in_v;
        cnt_up = in_v & ~fill_last;
        cnt_clear = in_v & fill_last;
        done_o = in_v & fill_last;
        if (in_v && fill_last) begin
          state_n = e_idle;
        end
      end
      // push the word read last cycle, read the next one
      e_send_evict_data: begin
        out_v = 1'b1;
        data_mem_v_o = out_ready & ~evict_last;
        cnt_up = out_ready & ~evict_last;
        cnt_clear = out_ready & evict_last;
        done_o = out_ready & evict_last;
        if (out_ready && evict_last) begin
          state_n = e_idle;
        end
      end
      default: begin
        state_n = e_idle;
      end
    endcase
  end

  assign snoop_we = (state_r == e_get_fill_data) && in_v
                    && (cnt_r[lg_block_lp-1:0] == dma_addr_i[2 +: lg_block_lp]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= data_mem_data_o;
    end
  end

  // control holds the command for the whole block transfer
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r != e_idle) |-> $stable(dma_cmd_i));

endmodule

//--- hw/cache_pkg.sv
// widths, opcode and dma command enums, request, response and dma packet structs
package cache_pkg;

  localparam int addr_width_c = 32;
  localparam int data_width_c = 32;

  typedef enum logic {
    e_op_load,
    e_op_store
  } cache_op_e;

  // commands from the miss sequencer to the block transfer engine
  typedef enum logic [2:0] {
    e_dma_nop,
    e_dma_send_fill_addr,
    e_dma_send_evict_addr,
    e_dma_get_fill_data,
    e_dma_send_evict_data
  } dma_cmd_e;

  typedef struct packed {
    cache_op_e                op;
    logic [addr_width_c-1:0]  addr;
    logic [data_width_c-1:0]  data;
  } cache_req_s;

  // data is zero for a store
  typedef struct packed {
    cache_op_e                op;
    logic [data_width_c-1:0]  data;
  } cache_resp_s;

  // addr is always block aligned
  typedef struct packed {
    logic                     write_not_read;
    logic [addr_width_c-1:0]  addr;
  } dma_pkt_s;

endpackage

//--- hw/cache_tag_mem.sv
// tag, valid and dirty arrays with round-robin victim pointers and hit detection
`timescale 1ns/1ps

module cache_tag_mem
  import cache_pkg::*;
  #(parameter int sets_p = 16,
    parameter int ways_p = 2,
    parameter int block_size_in_words_p = 4,
    localparam int lg_sets_lp = $clog2(sets_p),
    localparam int lg_ways_lp = $clog2(ways_p),
    localparam int tag_width_lp =
      addr_width_c - lg_sets_lp - $clog2(block_size_in_words_p) - 2
  ) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    v_i,
    input  logic [lg_sets_lp-1:0]   index_i,
    input  logic [tag_width_lp-1:0] tag_i,
    input  logic                    w_i,
    input  logic [lg_ways_lp-1:0]   w_way_i,
    input  logic [tag_width_lp-1:0] w_tag_i,
    input  logic                    w_dirty_i,
    input  logic                    set_dirty_i,
    output logic                    hit_o,
    output logic [lg_ways_lp-1:0]   hit_way_o,
    output logic [lg_ways_lp-1:0]   victim_way_o,
    output logic [tag_width_lp-1:0] victim_tag_o,
    output logic                    victim_dirty_o
  );

  logic [tag_width_lp-1:0] tag_r [sets_p][ways_p];
  logic [ways_p-1:0]       valid_r [sets_p];
  logic [ways_p-1:0]       dirty_r [sets_p];
  logic [lg_ways_lp-1:0]   rr_r [sets_p];
  logic [lg_sets_lp-1:0]   index_r;
  logic [ways_p-1:0]       hit_vec;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      index_r <= '0;
      for (int s = 0; s < sets_p; s++) begin
        valid_r[s] <= '0;
        rr_r[s] <= '0;
      end
    end else begin
      if (v_i) begin
        index_r <= index_i;
      end
      // a fill moves the victim pointer on to the next way
      if (w_i) begin
        valid_r[index_i][w_way_i] <= 1'b1;
        rr_r[index_i] <= (rr_r[index_i] == lg_ways_lp'(ways_p - 1)) ? '0
                                                                    : rr_r[index_i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_i) begin
      tag_r[index_i][w_way_i] <= w_tag_i;
      dirty_r[index_i][w_way_i] <= w_dirty_i;
    end
    if (set_dirty_i) begin
      dirty_r[index_i][w_way_i] <= 1'b1;
    end
  end

  // compare against the set latched at lookup
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < ways_p; w++) begin
      hit_vec[w] = valid_r[index_r][w] && (tag_r[index_r][w] == tag_i);
      if (hit_vec[w]) begin
        hit_way_o = lg_ways_lp'(w);
      end
    end
  end

  assign hit_o = |hit_vec;
  assign victim_way_o = rr_r[index_r];
  assign victim_tag_o = tag_r[index_r][victim_way_o];
  assign victim_dirty_o = valid_r[index_r][victim_way_o] & dirty_r[index_r][victim_way_o];

  // a block is never filled into a set that already holds it
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(hit_vec));

endmodule

//--- hw/cache_top.sv
// cache top level with control, tag and data arrays, dma engine and data array port mux
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
  #(parameter int sets_p = 16,
    parameter int ways_p = 2,
    parameter int block_size_in_words_p = 4,
    localparam int lg_sets_lp = $clog2(sets_p),
    localparam int lg_ways_lp = $clog2(ways_p),
    localparam int lg_block_lp = $clog2(block_size_in_words_p),
    localparam int tag_width_lp = addr_width_c - lg_sets_lp - lg_block_lp - 2,
    localparam int dm_addr_width_lp = lg_sets_lp + lg_block_lp
  ) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  cache_req_s              req_i,
    input  logic                    req_v_i,
    output logic                    req_yumi_o,
    output cache_resp_s             resp_o,
    output logic                    resp_v_o,
    input  logic                    resp_yumi_i,
    output dma_pkt_s                dma_pkt_o,
    output logic                    dma_pkt_v_o,
    input  logic                    dma_pkt_yumi_i,
    input  logic [data_width_c-1:0] dma_data_i,
    input  logic                    dma_data_v_i,
    output logic                    dma_data_ready_o,
    output logic [data_width_c-1:0] dma_data_o,
    output logic                    dma_data_v_o,
    input  logic                    dma_data_yumi_i
  );

  logic                    tag_v, tag_w, tag_set_dirty, tag_hit, victim_dirty;
  logic [lg_sets_lp-1:0]   tag_index;
  logic [tag_width_lp-1:0] tag, victim_tag;
  logic [lg_ways_lp-1:0]   tag_w_way, hit_way, victim_way;

  logic                            ctrl_dm_v, ctrl_dm_w, dma_dm_v, dma_dm_w, dm_v, dm_w;
  logic [dm_addr_width_lp-1:0]     ctrl_dm_addr, dma_dm_addr, dm_addr;
  logic [ways_p-1:0]               ctrl_dm_mask, dma_dm_mask, dm_mask;
  logic [data_width_c-1:0]         ctrl_dm_data, dma_dm_data, dm_wdata;
  logic [ways_p-1:0][data_width_c-1:0] dm_rdata;

  logic                    dma_active, dma_done;
  dma_cmd_e                dma_cmd;
  logic [lg_ways_lp-1:0]   dma_way;
  logic [addr_width_c-1:0] dma_addr;
  logic [data_width_c-1:0] snoop_word;

  cache_ctrl #(
    .sets_p(sets_p), .ways_p(ways_p), .block_size_in_words_p(block_size_in_words_p)
  ) u_ctrl (
    .clk_i, .reset_i, .req_i, .req_v_i, .req_yumi_o, .resp_o, .resp_v_o, .resp_yumi_i,
    .tag_v_o(tag_v), .tag_index_o(tag_index), .tag_o(tag), .tag_w_o(tag_w),
    .tag_w_way_o(tag_w_way), .tag_set_dirty_o(tag_set_dirty),
    .tag_hit_i(tag_hit), .tag_hit_way_i(hit_way), .victim_way_i(victim_way),
    .victim_tag_i(victim_tag), .victim_dirty_i(victim_dirty),
    .data_mem_v_o(ctrl_dm_v), .data_mem_w_o(ctrl_dm_w), .data_mem_addr_o(ctrl_dm_addr),
    .data_mem_w_mask_o(ctrl_dm_mask), .data_mem_data_o(ctrl_dm_data),
    .data_mem_data_i(dm_rdata), .dma_active_o(dma_active), .dma_cmd_o(dma_cmd),
    .dma_way_o(dma_way), .dma_addr_o(dma_addr), .dma_done_i(dma_done),
    .snoop_word_i(snoop_word)
  );

  // new tags are written clean, stores mark them dirty afterwards
  cache_tag_mem #(
    .sets_p(sets_p), .ways_p(ways_p), .block_size_in_words_p(block_size_in_words_p)
  ) u_tag_mem (
    .clk_i, .reset_i, .v_i(tag_v), .index_i(tag_index), .tag_i(tag), .w_i(tag_w),
    .w_way_i(tag_w_way), .w_tag_i(tag), .w_dirty_i(1'b0), .set_dirty_i(tag_set_dirty),
    .hit_o(tag_hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
    .victim_tag_o(victim_tag), .victim_dirty_o(victim_dirty)
  );

  // dma engine owns the data array during block transfers
  assign dm_v     = dma_active ? dma_dm_v    : ctrl_dm_v;
  assign dm_w     = dma_active ? dma_dm_w    : ctrl_dm_w;
  assign dm_addr  = dma_active ? dma_dm_addr : ctrl_dm_addr;
  assign dm_mask  = dma_active ? dma_dm_mask : ctrl_dm_mask;
  assign dm_wdata = dma_active ? dma_dm_data : ctrl_dm_data;

  cache_data_mem #(
    .sets_p(sets_p), .ways_p(ways_p), .block_size_in_words_p(block_size_in_words_p)
  ) u_data_mem (
    .clk_i, .v_i(dm_v), .w_i(dm_w), .addr_i(dm_addr), .w_mask_i(dm_mask),
    .data_i(dm_wdata), .data_o(dm_rdata)
  );

  cache_dma #(
    .sets_p(sets_p), .ways_p(ways_p), .block_size_in_words_p(block_size_in_words_p)
  ) u_dma (
    .clk_i, .reset_i, .dma_cmd_i(dma_cmd), .dma_way_i(dma_way), .dma_addr_i(dma_addr),
    .done_o(dma_done), .snoop_word_o(snoop_word),
    .dma_pkt_o, .dma_pkt_v_o, .dma_pkt_yumi_i,
    .dma_data_i, .dma_data_v_i, .dma_data_ready_o,
    .dma_data_o, .dma_data_v_o, .dma_data_yumi_i,
    .data_mem_v_o(dma_dm_v), .data_mem_w_o(dma_dm_w), .data_mem_addr_o(dma_dm_addr),
    .data_mem_w_mask_o(dma_dm_mask), .data_mem_data_o(dma_dm_data),
    .data_mem_data_i(dm_rdata)
  );

endmodule

//--- list.f
hw/cache_pkg.sv
hw/cache_tag_mem.sv
hw/cache_data_mem.sv
hw/cache_dma.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/tb_cache_top.sv

//--- test/tb_cache_top.sv
// cache testbench with clock, reset, random requests, dma memory model, reference model, watchdog
`timescale 1ns/1ps

module tb_cache_top
  import cache_pkg::*;
  ();

  localparam int sets_c = 4;
  localparam int ways_c = 2;
  localparam int block_c = 4;
  localparam int clk_period_c = 40;
  localparam int drive_delay_c = 2;
  // eight times the cache capacity of 32 words
  localparam int region_words_c = 256;
  localparam logic [31:0] base_addr_c = 32'h2468_0000;
  localparam int reset_loads_c = 16;
  localparam int store_pairs_c = 8;
  localparam int random_reqs_c = 400;
  localparam int total_reqs_c = reset_loads_c + 2 * store_pairs_c + 6 + random_reqs_c;
  localparam int cycles_per_req_c = 300;
  localparam int num_tests_c = 5;

  typedef struct packed {
    cache_op_e   op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0]  test;
  } pending_s;

  logic        clk_i;
  logic        reset_i;
  cache_req_s  req_i;
  logic        req_v_i;
  logic        req_yumi_o;
  cache_resp_s resp_o;
  logic        resp_v_o;
  logic        resp_yumi_i;
  dma_pkt_s    dma_pkt_o;
  logic        dma_pkt_v_o;
  logic        dma_pkt_yumi_i;
  logic [31:0] dma_data_i;
  logic        dma_data_v_i;
  logic        dma_data_ready_o;
  logic [31:0] dma_data_o;
  logic        dma_data_v_o;
  logic        dma_data_yumi_i;

  // memory behind the dma port and the reference word map
  logic [31:0] mem_r [region_words_c];
  logic [31:0] ref_r [region_words_c];
  logic        written_r [region_words_c];

  pending_s pending_q [$];
  string test_names [num_tests_c] = '{"reset_loads", "store_load", "random", "evict", "handshake"};
  int err_cnt [num_tests_c];
  int check_cnt [num_tests_c];
  int cur_test;
  int req_cnt;
  int resp_cnt;
  int evict_blocks;

  cache_top #(
    .sets_p(sets_c), .ways_p(ways_c), .block_size_in_words_p(block_c)
  ) u_dut (
    .clk_i, .reset_i, .req_i, .req_v_i, .req_yumi_o, .resp_o, .resp_v_o, .resp_yumi_i,
    .dma_pkt_o, .dma_pkt_v_o, .dma_pkt_yumi_i,
    .dma_data_i, .dma_data_v_i, .dma_data_ready_o,
    .dma_data_o, .dma_data_v_o, .dma_data_yumi_i
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  // initial memory contents hash the full byte address
  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (written_r[addr[9:2]]) begin
      return ref_r[addr[9:2]];
    end
    return init_word(addr);
  endfunction

  function automatic logic [31:0] rand_addr();
    return base_addr_c | (32'($urandom % region_words_c) << 2);
  endfunction

  // same set but another tag
  function automatic logic [31:0] conflict_addr(input logic [31:0] addr, input int k);
    return {addr[31:10], addr[9:6] + 4'(k), addr[5:0]};
  endfunction

  task automatic issue(input cache_op_e op, input logic [31:0] addr, input logic [31:0] data);
    pending_s p;
    int gap;
    gap = $urandom % 3;
    repeat (gap) @(posedge clk_i);
    #(drive_delay_c);
    req_i.op = op;
    req_i.addr = addr;
    req_i.data = data;
    req_v_i = 1'b1;
    do @(posedge clk_i); while (!req_yumi_o);
    p.op = op;
    p.addr = addr;
    p.data = data;
    p.test = 3'(cur_test);
    pending_q.push_back(p);
    req_cnt++;
    #(drive_delay_c);
    req_v_i = 1'b0;
    req_i = '0;
    do @(posedge clk_i); while (!(resp_v_o && resp_yumi_i));
  endtask

  task automatic check_response(input pending_s p, input cache_resp_s r);
    logic [31:0] exp;
    check_cnt[p.test]++;
    if (r.op !== p.op) begin
      $display("Mismatch in %s: expected op %0d, actual op %0d", test_names[p.test], p.op, r.op);
      err_cnt[p.test]++;
    end
    if (p.op == e_op_store) begin
      exp = '0;
      ref_r[p.addr[9:2]] = p.data;
      written_r[p.addr[9:2]] = 1'b1;
    end else begin
      exp = expected_word(p.addr);
    end
    if (r.data !== exp) begin
      $display("Mismatch in %s: expected %h, actual %h at address %h",
               test_names[p.test], exp, r.data, p.addr);
      err_cnt[p.test]++;
    end
  endtask

  // the last response of a test is checked by the monitor in the same time step
  task automatic report_test(input int t);
    wait (resp_cnt >= req_cnt);
    $display("test %-12s %0d checks, %0d errors, %s", test_names[t], check_cnt[t], err_cnt[t],
             (err_cnt[t] == 0) ? "passed" : "failed");
  endtask

  initial begin : response_monitor
    pending_s p;
    forever begin
      @(posedge clk_i);
      if (!reset_i && resp_v_o && resp_yumi_i) begin
        if (pending_q.size() == 0) begin
          $display("Error in handshake: response arrived with no request outstanding");
          err_cnt[4]++;
        end else begin
          p = pending_q.pop_front();
          check_response(p, resp_o);
        end
        resp_cnt++;
      end
    end
  end

  // memory model that also drives the random response back-pressure
  initial begin : memory_model
    logic [31:0] evict_addr;
    logic [31:0] fill_addr;
    logic [31:0] exp;
    int evict_left;
    int fill_left;
    logic fill_xfer;
    resp_yumi_i = 1'b0;
    dma_pkt_yumi_i = 1'b0;
    dma_data_i = '0;
    dma_data_v_i = 1'b0;
    dma_data_yumi_i = 1'b0;
    evict_addr = '0;
    fill_addr = '0;
    evict_left = 0;
    fill_left = 0;
    for (int i = 0; i < region_words_c; i++) begin
      mem_r[i] = init_word(base_addr_c | 32'(i << 2));
    end
    forever begin
      @(posedge clk_i);
      fill_xfer = dma_data_v_i && dma_data_ready_o;
      if (!reset_i) begin
        if (fill_xfer) begin
          fill_left--;
          fill_addr += 4;
        end
        if (dma_data_v_o && dma_data_yumi_i) begin
          if (evict_left == 0) begin
            $display("Error in evict: evict word with no evict packet pending");
            err_cnt[3]++;
          end else begin
            exp = expected_word(evict_addr);
            check_cnt[3]++;
            if (dma_data_o !== exp) begin
              $display("Mismatch in %s: expected %h, actual %h at address %h",
                       test_names[3], exp, dma_data_o, evict_addr);
              err_cnt[3]++;
            end
            mem_r[evict_addr[9:2]] = dma_data_o;
            evict_addr += 4;
            evict_left--;
          end
        end
        if (dma_pkt_v_o && dma_pkt_yumi_i) begin
          if (dma_pkt_o.addr[3:0] != 4'd0 || dma_pkt_o.addr[31:10] != base_addr_c[31:10]) begin
            $display("Error in evict: packet address %h is not a block in the test region",
                     dma_pkt_o.addr);
            err_cnt[3]++;
          end
          if (dma_pkt_o.write_not_read) begin
            if (evict_left != 0) begin
              $display("Error in evict: evict packet before the previous block was written");
              err_cnt[3]++;
            end
            evict_addr = dma_pkt_o.addr;
            evict_left = block_c;
            evict_blocks++;
          end else begin
            if (fill_left != 0) begin
              $display("Error in handshake: fill packet before the previous fill ended");
              err_cnt[4]++;
            end
            fill_addr = dma_pkt_o.addr;
            fill_left = block_c;
          end
        end
      end
      #(drive_delay_c);
      resp_yumi_i = resp_v_o && ($urandom % 4 != 0);
      dma_pkt_yumi_i = dma_pkt_v_o && ($urandom % 3 != 0);
      dma_data_yumi_i = dma_data_v_o && ($urandom % 3 != 0);
      // a stalled fill word stays put and reads wait for pending evict writes
      if (!(dma_data_v_i && !fill_xfer)) begin
        dma_data_v_i = !reset_i && fill_left > 0 && evict_left == 0 && ($urandom % 4 != 0);
        dma_data_i = dma_data_v_i ? mem_r[fill_addr[9:2]] : '0;
      end
    end
  end

  initial begin
    #(clk_period_c * (total_reqs_c * cycles_per_req_c + 100));
    $display("Error: watchdog expired with %0d requests and %0d responses", req_cnt, resp_cnt);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] a;
    logic [31:0] d;
    cache_op_e op;
    int passed;
    int errors;
    void'($urandom(32));
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_i = '0;
    for (int i = 0; i < region_words_c; i++) begin
      written_r[i] = 1'b0;
      ref_r[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #(drive_delay_c);
    reset_i = 1'b0;
    @(posedge clk_i);

    cur_test = 0;
    for (int i = 0; i < reset_loads_c; i++) begin
      issue(e_op_load, rand_addr(), '0);
    end
    report_test(0);

    cur_test = 1;
    for (int i = 0; i < store_pairs_c; i++) begin
      a = rand_addr();
      d = $urandom;
      issue(e_op_store, a, d);
      issue(e_op_load, a, '0);
    end
    // four conflicting blocks push the stored block out so the last load misses
    a = rand_addr();
    issue(e_op_store, a, $urandom);
    for (int k = 1; k <= 4; k++) begin
      issue(e_op_load, conflict_addr(a, k), '0);
    end
    issue(e_op_load, a, '0);
    report_test(1);

    cur_test = 2;
    for (int i = 0; i < random_reqs_c; i++) begin
      op = ($urandom % 2 != 0) ? e_op_store : e_op_load;
      d = $urandom;
      issue(op, rand_addr(), d);
    end
    report_test(2);

    repeat (20) @(posedge clk_i);
    check_cnt[3]++;
    if (evict_blocks == 0) begin
      $display("Error in evict: no dirty block was ever written back");
      err_cnt[3]++;
    end
    report_test(3);

    cur_test = 4;
    check_cnt[4]++;
    if (resp_cnt != req_cnt || pending_q.size() != 0) begin
      $display("Error in handshake: %0d responses for %0d requests", resp_cnt, req_cnt);
      err_cnt[4]++;
    end
    report_test(4);

    passed = 0;
    errors = 0;
    for (int t = 0; t < num_tests_c; t++) begin
      errors += err_cnt[t];
      if (err_cnt[t] == 0) begin
        passed++;
      end
    end
    $display("tests: %0d passed, %0d failed, %0d errors, %0d evicted blocks",
             passed, num_tests_c - passed, errors, evict_blocks);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
